// File: hw/uc_addr_pkg.sv
`default_nettype none

package uc_addr_pkg;

  localparam int paddr_width   = 32;
  localparam int dword_width   = 64;
  localparam int dev_id_width  = 4;
  localparam int reg_off_width = 20;

  typedef logic [paddr_width-1:0]   paddr_t;
  typedef logic [dword_width-1:0]   dword_t;
  typedef logic [dev_id_width-1:0]  dev_id_t;
  typedef logic [reg_off_width-1:0] reg_off_t;

  // Everything below this is local device space
  localparam paddr_t dram_base_addr = 32'h8000_0000;

  // Local device ids, address bits 23 to 20
  localparam dev_id_t host_dev  = 4'd0;
  localparam dev_id_t clint_dev = 4'd1;
  localparam dev_id_t cfg_dev   = 4'd2;
  localparam dev_id_t cache_dev = 4'd3;
  localparam dev_id_t boot_dev  = 4'd4;

  // CLINT register offsets
  localparam reg_off_t msip_off     = 20'h0_0000;
  localparam reg_off_t mtimecmp_off = 20'h0_4000;
  localparam reg_off_t meip_off     = 20'h0_b000;
  localparam reg_off_t mtime_off    = 20'h0_bff8;

  // Config register offsets
  localparam reg_off_t freeze_off    = 20'h0_0000;
  localparam reg_off_t core_id_off   = 20'h0_0008;
  localparam reg_off_t icache_id_off = 20'h0_0010;
  localparam reg_off_t dcache_id_off = 20'h0_0018;

  typedef enum logic [1:0] {
    sink_cfg,
    sink_clint,
    sink_mem,
    sink_loopback
  } sink_e;

endpackage

`default_nettype wire

// File: hw/uc_msg_pkg.sv
`default_nettype none

package uc_msg_pkg;

  import uc_addr_pkg::*;

  localparam int core_id_width = 4;

  typedef enum logic {
    op_rd = 1'b0,
    op_wr = 1'b1
  } msg_op_e;

  typedef logic [core_id_width-1:0] core_id_t;

  // Single-beat command
  typedef struct packed {
    msg_op_e op;
    paddr_t  addr;
    dword_t  data;
  } uc_cmd_t;

  // Data holds the read value, zero for writes
  typedef struct packed {
    msg_op_e op;
    paddr_t  addr;
    dword_t  data;
  } uc_resp_t;

  typedef struct packed {
    logic     freeze;
    core_id_t core_id;
    core_id_t icache_id;
    core_id_t dcache_id;
  } uc_cfg_bus_t;

endpackage

`default_nettype wire

// File: hw/uc_cfg_regs.sv
`default_nettype none

module uc_cfg_regs
  import uc_addr_pkg::*;
  import uc_msg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  uc_cmd_t     cmd_i,
  input  logic        cmd_v_i,
  output logic        cmd_ready_o,
  output uc_resp_t    resp_o,
  output logic        resp_v_o,
  input  logic        resp_ready_i,
  output uc_cfg_bus_t cfg_bus_o
);

  uc_cfg_bus_t cfg_q;
  uc_resp_t    resp_q;
  logic        resp_v_q;
  reg_off_t    off;
  dword_t      rd_data;
  logic        cmd_fire;

  assign off         = cmd_i.addr[reg_off_width-1:0];
  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  always_comb
  begin
    case (off)
      freeze_off:    rd_data = dword_t'(cfg_q.freeze);
      core_id_off:   rd_data = dword_t'(cfg_q.core_id);
      icache_id_off: rd_data = dword_t'(cfg_q.icache_id);
      dcache_id_off: rd_data = dword_t'(cfg_q.dcache_id);
      default:       rd_data = '0;
    endcase
  end

  // Core comes out of reset frozen
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cfg_q <= '{freeze: 1'b1, default: '0};
    end
    else if (cmd_fire && (cmd_i.op == op_wr))
    begin
      case (off)
        freeze_off:    cfg_q.freeze    <= cmd_i.data[0];
        core_id_off:   cfg_q.core_id   <= core_id_t'(cmd_i.data);
        icache_id_off: cfg_q.icache_id <= core_id_t'(cmd_i.data);
        dcache_id_off: cfg_q.dcache_id <= core_id_t'(cmd_i.data);
        default:       ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_q <= 1'b0;
    end
    else if (cmd_fire)
    begin
      resp_v_q <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.op   <= cmd_i.op;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= (cmd_i.op == op_rd) ? rd_data : '0;
    end
  end

  assign resp_o    = resp_q;
  assign resp_v_o  = resp_v_q;
  assign cfg_bus_o = cfg_q;

endmodule

`default_nettype wire

// File: hw/uc_clint.sv
`default_nettype none

module uc_clint
  import uc_addr_pkg::*;
  import uc_msg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  uc_cmd_t  cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output uc_resp_t resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i,
  output logic     timer_irq_o,
  output logic     software_irq_o,
  output logic     external_irq_o
);

  dword_t   mtime_q, mtimecmp_q;
  logic     msip_q, meip_q;
  uc_resp_t resp_q;
  logic     resp_v_q;
  reg_off_t off;
  dword_t   rd_data;
  logic     cmd_fire, wr_fire;

  assign off         = cmd_i.addr[reg_off_width-1:0];
  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign wr_fire     = cmd_fire & (cmd_i.op == op_wr);

  // Free-running machine timer
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q <= '0;
    end
    else
    begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // Compare starts at all ones so the timer irq stays low
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      meip_q     <= 1'b0;
    end
    else if (wr_fire)
    begin
      case (off)
        mtimecmp_off: mtimecmp_q <= cmd_i.data;
        msip_off:     msip_q     <= cmd_i.data[0];
        meip_off:     meip_q     <= cmd_i.data[0];
        default:      ;
      endcase
    end
  end

  always_comb
  begin
    case (off)
      msip_off:     rd_data = dword_t'(msip_q);
      mtimecmp_off: rd_data = mtimecmp_q;
      meip_off:     rd_data = dword_t'(meip_q);
      mtime_off:    rd_data = mtime_q;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_q <= 1'b0;
    end
    else if (cmd_fire)
    begin
      resp_v_q <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.op   <= cmd_i.op;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= (cmd_i.op == op_rd) ? rd_data : '0;
    end
  end

  assign resp_o         = resp_q;
  assign resp_v_o       = resp_v_q;
  assign timer_irq_o    = (mtime_q >= mtimecmp_q);
  assign software_irq_o = msip_q;
  assign external_irq_o = meip_q;

endmodule

`default_nettype wire

// File: hw/uc_loopback.sv
`default_nettype none

module uc_loopback
  import uc_msg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  uc_cmd_t  cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output uc_resp_t resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i
);

  uc_resp_t resp_q;
  logic     resp_v_q;
  logic     cmd_fire;

  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_q <= 1'b0;
    end
    else if (cmd_fire)
    begin
      resp_v_q <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_q <= 1'b0;
    end
  end

  // Echo op and addr, data always reads as zero
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.op   <= cmd_i.op;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= '0;
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

`default_nettype wire

// File: hw/uc_cmd_router.sv
`default_nettype none

module uc_cmd_router
  import uc_addr_pkg::*;
  import uc_msg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  uc_cmd_t  host_cmd_i,
  input  logic     host_cmd_v_i,
  output logic     host_cmd_ready_o,
  output uc_resp_t host_resp_o,
  output logic     host_resp_v_o,
  input  logic     host_resp_ready_i,

  output uc_cmd_t  cfg_cmd_o,
  output logic     cfg_cmd_v_o,
  input  logic     cfg_cmd_ready_i,
  input  uc_resp_t cfg_resp_i,
  input  logic     cfg_resp_v_i,
  output logic     cfg_resp_ready_o,

  output uc_cmd_t  clint_cmd_o,
  output logic     clint_cmd_v_o,
  input  logic     clint_cmd_ready_i,
  input  uc_resp_t clint_resp_i,
  input  logic     clint_resp_v_i,
  output logic     clint_resp_ready_o,

  output uc_cmd_t  loop_cmd_o,
  output logic     loop_cmd_v_o,
  input  logic     loop_cmd_ready_i,
  input  uc_resp_t loop_resp_i,
  input  logic     loop_resp_v_i,
  output logic     loop_resp_ready_o,

  output uc_cmd_t  mem_cmd_o,
  output logic     mem_cmd_v_o,
  input  logic     mem_cmd_ready_i,
  input  uc_resp_t mem_resp_i,
  input  logic     mem_resp_v_i,
  output logic     mem_resp_ready_o
);

  typedef enum logic {
    idle,
    wait_resp
  } state_e;

  state_e  state_q;
  sink_e   sink_sel, sink_q;
  dev_id_t dev_id;
  logic    cmd_local, sel_ready, resp_v_sel;
  logic    is_idle, cmd_fire, resp_fire;

  assign dev_id    = host_cmd_i.addr[reg_off_width +: dev_id_width];
  assign cmd_local = (host_cmd_i.addr < dram_base_addr);

  // Address decode
  always_comb
  begin
    sink_sel = sink_mem;
    if (cmd_local)
    begin
      case (dev_id)
        cfg_dev:                       sink_sel = sink_cfg;
        clint_dev:                     sink_sel = sink_clint;
        host_dev, boot_dev, cache_dev: sink_sel = sink_mem;
        default:                       sink_sel = sink_loopback;
      endcase
    end
  end

  always_comb
  begin
    case (sink_sel)
      sink_cfg:   sel_ready = cfg_cmd_ready_i;
      sink_clint: sel_ready = clint_cmd_ready_i;
      sink_mem:   sel_ready = mem_cmd_ready_i;
      default:    sel_ready = loop_cmd_ready_i;
    endcase
  end

  assign is_idle          = (state_q == idle);
  assign host_cmd_ready_o = is_idle & sel_ready;
  assign cmd_fire         = host_cmd_v_i & host_cmd_ready_o;

  // Payload goes to every sink, only the chosen one sees valid
  assign cfg_cmd_o   = host_cmd_i;
  assign clint_cmd_o = host_cmd_i;
  assign loop_cmd_o  = host_cmd_i;
  assign mem_cmd_o   = host_cmd_i;

  assign cfg_cmd_v_o   = is_idle & host_cmd_v_i & (sink_sel == sink_cfg);
  assign clint_cmd_v_o = is_idle & host_cmd_v_i & (sink_sel == sink_clint);
  assign loop_cmd_v_o  = is_idle & host_cmd_v_i & (sink_sel == sink_loopback);
  assign mem_cmd_v_o   = is_idle & host_cmd_v_i & (sink_sel == sink_mem);

  // Response return from the held sink
  always_comb
  begin
    case (sink_q)
      sink_cfg:
      begin
        host_resp_o = cfg_resp_i;
        resp_v_sel  = cfg_resp_v_i;
      end
      sink_clint:
      begin
        host_resp_o = clint_resp_i;
        resp_v_sel  = clint_resp_v_i;
      end
      sink_mem:
      begin
        host_resp_o = mem_resp_i;
        resp_v_sel  = mem_resp_v_i;
      end
      default:
      begin
        host_resp_o = loop_resp_i;
        resp_v_sel  = loop_resp_v_i;
      end
    endcase
  end

  assign host_resp_v_o = ~is_idle & resp_v_sel;
  assign resp_fire     = host_resp_v_o & host_resp_ready_i;

  assign cfg_resp_ready_o   = ~is_idle & (sink_q == sink_cfg) & host_resp_ready_i;
  assign clint_resp_ready_o = ~is_idle & (sink_q == sink_clint) & host_resp_ready_i;
  assign loop_resp_ready_o  = ~is_idle & (sink_q == sink_loopback) & host_resp_ready_i;
  assign mem_resp_ready_o   = ~is_idle & (sink_q == sink_mem) & host_resp_ready_i;

  // One transaction in flight
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= idle;
      sink_q  <= sink_cfg;
    end
    else
    begin
      case (state_q)
        idle:
        begin
          if (cmd_fire)
          begin
            state_q <= wait_resp;
            sink_q  <= sink_sel;
          end
        end
        wait_resp:
        begin
          if (resp_fire)
          begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/uc_lite_top.sv
`default_nettype none

module uc_lite_top
  import uc_msg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  uc_cmd_t     host_cmd_i,
  input  logic        host_cmd_v_i,
  output logic        host_cmd_ready_o,
  output uc_resp_t    host_resp_o,
  output logic        host_resp_v_o,
  input  logic        host_resp_ready_i,

  output uc_cmd_t     mem_cmd_o,
  output logic        mem_cmd_v_o,
  input  logic        mem_cmd_ready_i,
  input  uc_resp_t    mem_resp_i,
  input  logic        mem_resp_v_i,
  output logic        mem_resp_ready_o,

  output uc_cfg_bus_t cfg_bus_o,
  output logic        timer_irq_o,
  output logic        software_irq_o,
  output logic        external_irq_o
);

  uc_cmd_t  cfg_cmd, clint_cmd, loop_cmd;
  uc_resp_t cfg_resp, clint_resp, loop_resp;
  logic     cfg_cmd_v, cfg_cmd_ready, cfg_resp_v, cfg_resp_ready;
  logic     clint_cmd_v, clint_cmd_ready, clint_resp_v, clint_resp_ready;
  logic     loop_cmd_v, loop_cmd_ready, loop_resp_v, loop_resp_ready;

  uc_cmd_router router (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .host_cmd_i        (host_cmd_i),
    .host_cmd_v_i      (host_cmd_v_i),
    .host_cmd_ready_o  (host_cmd_ready_o),
    .host_resp_o       (host_resp_o),
    .host_resp_v_o     (host_resp_v_o),
    .host_resp_ready_i (host_resp_ready_i),
    .cfg_cmd_o         (cfg_cmd),
    .cfg_cmd_v_o       (cfg_cmd_v),
    .cfg_cmd_ready_i   (cfg_cmd_ready),
    .cfg_resp_i        (cfg_resp),
    .cfg_resp_v_i      (cfg_resp_v),
    .cfg_resp_ready_o  (cfg_resp_ready),
    .clint_cmd_o       (clint_cmd),
    .clint_cmd_v_o     (clint_cmd_v),
    .clint_cmd_ready_i (clint_cmd_ready),
    .clint_resp_i      (clint_resp),
    .clint_resp_v_i    (clint_resp_v),
    .clint_resp_ready_o(clint_resp_ready),
    .loop_cmd_o        (loop_cmd),
    .loop_cmd_v_o      (loop_cmd_v),
    .loop_cmd_ready_i  (loop_cmd_ready),
    .loop_resp_i       (loop_resp),
    .loop_resp_v_i     (loop_resp_v),
    .loop_resp_ready_o (loop_resp_ready),
    .mem_cmd_o         (mem_cmd_o),
    .mem_cmd_v_o       (mem_cmd_v_o),
    .mem_cmd_ready_i   (mem_cmd_ready_i),
    .mem_resp_i        (mem_resp_i),
    .mem_resp_v_i      (mem_resp_v_i),
    .mem_resp_ready_o  (mem_resp_ready_o)
  );

  uc_cfg_regs cfg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (cfg_cmd),
    .cmd_v_i     (cfg_cmd_v),
    .cmd_ready_o (cfg_cmd_ready),
    .resp_o      (cfg_resp),
    .resp_v_o    (cfg_resp_v),
    .resp_ready_i(cfg_resp_ready),
    .cfg_bus_o   (cfg_bus_o)
  );

  uc_clint clint (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_i         (clint_cmd),
    .cmd_v_i       (clint_cmd_v),
    .cmd_ready_o   (clint_cmd_ready),
    .resp_o        (clint_resp),
    .resp_v_o      (clint_resp_v),
    .resp_ready_i  (clint_resp_ready),
    .timer_irq_o   (timer_irq_o),
    .software_irq_o(software_irq_o),
    .external_irq_o(external_irq_o)
  );

  uc_loopback loopback (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (loop_cmd),
    .cmd_v_i     (loop_cmd_v),
    .cmd_ready_o (loop_cmd_ready),
    .resp_o      (loop_resp),
    .resp_v_o    (loop_resp_v),
    .resp_ready_i(loop_resp_ready)
  );

endmodule

`default_nettype wire

// File: dv/uc_lite_sva.sv
`default_nettype none

module uc_lite_sva
  import uc_msg_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     host_cmd_v_i,
  input logic     host_cmd_ready_o,
  input uc_resp_t host_resp_o,
  input logic     host_resp_v_o,
  input logic     host_resp_ready_i,
  input logic     cfg_cmd_v_o,
  input logic     clint_cmd_v_o,
  input logic     loop_cmd_v_o,
  input logic     mem_cmd_v_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic pending_q;

  // Set from command transfer until the host takes the response
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      pending_q <= 1'b0;
    end
    else if (host_cmd_v_i && host_cmd_ready_o)
    begin
      pending_q <= 1'b1;
    end
    else if (host_resp_v_o && host_resp_ready_i)
    begin
      pending_q <= 1'b0;
    end
  end

  // Response held under back-pressure
  resp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_resp_v_o && !host_resp_ready_i |=> host_resp_v_o && $stable(host_resp_o))
    else $error("host response changed while stalled");

  no_cmd_while_pending_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pending_q |-> !host_cmd_ready_o)
    else $error("command ready while a response is pending");

  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_n_i |-> !mem_cmd_v_o)
    else $error("memory command valid during reset");

  // One sink sees the offered command
  one_sink_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pending_q && host_cmd_v_i |->
      $onehot({cfg_cmd_v_o, clint_cmd_v_o, loop_cmd_v_o, mem_cmd_v_o}))
    else $error("sink valids not one-hot");

endmodule

bind uc_cmd_router uc_lite_sva sva (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .host_cmd_v_i     (host_cmd_v_i),
  .host_cmd_ready_o (host_cmd_ready_o),
  .host_resp_o      (host_resp_o),
  .host_resp_v_o    (host_resp_v_o),
  .host_resp_ready_i(host_resp_ready_i),
  .cfg_cmd_v_o      (cfg_cmd_v_o),
  .clint_cmd_v_o    (clint_cmd_v_o),
  .loop_cmd_v_o     (loop_cmd_v_o),
  .mem_cmd_v_o      (mem_cmd_v_o)
);

`default_nettype wire

// File: dv/uc_lite_tb.sv
`default_nettype none

module uc_lite_tb
  import uc_addr_pkg::*;
  import uc_msg_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  // Kind column: 0 local with masked data, 1 memory port, 2 mtime read
  typedef struct packed {
    msg_op_e     op;
    paddr_t      addr;
    dword_t      wdata;
    dword_t      exp;
    dword_t      mask;
    logic [2:0]  irq;
    uc_cfg_bus_t cfg;
    logic [1:0]  kind;
  } stim_t;

  localparam dword_t mem_pattern = 64'h5a5a_c3c3_0f0f_9696;

  logic        clk_i;
  logic        rst_n_i;
  uc_cmd_t     host_cmd_i;
  logic        host_cmd_v_i;
  logic        host_cmd_ready_o;
  uc_resp_t    host_resp_o;
  logic        host_resp_v_o;
  logic        host_resp_ready_i;
  uc_cmd_t     mem_cmd_o;
  logic        mem_cmd_v_o;
  logic        mem_cmd_ready_i;
  uc_resp_t    mem_resp_i;
  logic        mem_resp_v_i;
  logic        mem_resp_ready_o;
  uc_cfg_bus_t cfg_bus_o;
  logic        timer_irq_o;
  logic        software_irq_o;
  logic        external_irq_o;

  stim_t       stims[$];
  uc_cmd_t     cur_cmd;
  logic        mem_expect;
  int unsigned rand_state;
  int unsigned cycles;
  int unsigned cycle_limit;
  int          mem_seen;
  int          mem_wanted;

  uc_lite_top dut (.*);

  function automatic dword_t mem_data(input uc_cmd_t cmd);
    return (cmd.op == op_rd) ? (dword_t'(cmd.addr) ^ mem_pattern) : '0;
  endfunction

  function int unsigned next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 16;
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(input uc_resp_t got, input uc_resp_t exp, input dword_t mask);
    if (got.op !== exp.op || got.addr !== exp.addr || (got.data & mask) !== (exp.data & mask))
    begin
      $display("[ERROR] host_resp_o got op %h addr %h data %h, expected op %h addr %h data %h",
               got.op, got.addr, got.data, exp.op, exp.addr, exp.data & mask);
      abort_run();
    end
  endtask

  task automatic check_cmd(input uc_cmd_t got, input uc_cmd_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] mem_cmd_o got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_cfg(input uc_cfg_bus_t got, input uc_cfg_bus_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] cfg_bus_o got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_irq(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] irq {timer, software, external} got %h, expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic load_stimulus();
    int     fd;
    int     cnt;
    string  line;
    logic [63:0] f_op, f_addr, f_wd, f_exp, f_mask, f_irq, f_cfg, f_kind;
    stim_t  s;
    fd = $fopen("dv/uc_lite_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file");
      abort_run();
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    f_op, f_addr, f_wd, f_exp, f_mask, f_irq, f_cfg, f_kind);
      if (cnt == 8)
      begin
        s.op    = msg_op_e'(f_op[0]);
        s.addr  = paddr_t'(f_addr);
        s.wdata = f_wd;
        s.exp   = f_exp;
        s.mask  = f_mask;
        s.irq   = f_irq[2:0];
        s.cfg   = uc_cfg_bus_t'(f_cfg[12:0]);
        s.kind  = f_kind[1:0];
        stims.push_back(s);
      end
    end
    $fclose(fd);
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #5 clk_i = ~clk_i;
    end
  end

  // Watchdog on total cycles
  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge clk_i);
      cycles++;
      if (cycles > cycle_limit)
      begin
        $display("Timeout: the run took more than %0d cycles", cycle_limit);
        abort_run();
      end
    end
  end

  // Memory model with random response delay
  initial
  begin
    uc_cmd_t     got;
    int unsigned delay;
    mem_cmd_ready_i = 1'b1;
    mem_resp_v_i    = 1'b0;
    mem_resp_i      = '0;
    forever
    begin
      @(negedge clk_i);
      if (rst_n_i && mem_cmd_v_o && mem_cmd_ready_i)
      begin
        got = mem_cmd_o;
        if (!mem_expect)
        begin
          $display("A local command appeared on the memory port");
          abort_run();
        end
        check_cmd(got, cur_cmd);
        mem_seen++;
        @(posedge clk_i);
        delay = next_rand() % 8;
        repeat (delay) @(posedge clk_i);
        #1;
        mem_resp_i   = '{op: got.op, addr: got.addr, data: mem_data(got)};
        mem_resp_v_i = 1'b1;
        do @(negedge clk_i); while (!mem_resp_ready_o);
        @(posedge clk_i);
        #1;
        mem_resp_v_i = 1'b0;
        mem_resp_i   = '0;
      end
    end
  end

  initial
  begin
    stim_t       s;
    uc_resp_t    exp_resp;
    uc_resp_t    got;
    dword_t      prev_mtime;
    logic        have_mtime;
    int unsigned stall;
    rst_n_i           = 1'b0;
    host_cmd_i        = '0;
    host_cmd_v_i      = 1'b0;
    host_resp_ready_i = 1'b0;
    cur_cmd           = '0;
    mem_expect        = 1'b0;
    rand_state        = 32'd14;
    mem_seen          = 0;
    mem_wanted        = 0;
    have_mtime        = 1'b0;
    prev_mtime        = '0;
    cycle_limit       = 32'hffff_ffff;
    load_stimulus();
    cycle_limit = stims.size() * 16 + 20;

    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_cfg(cfg_bus_o, '{freeze: 1'b1, default: '0});
    check_irq({timer_irq_o, software_irq_o, external_irq_o}, 3'b000);
    if (!host_cmd_ready_o || host_resp_v_o)
    begin
      $display("Host port is not idle after reset");
      abort_run();
    end

    foreach (stims[i])
    begin
      s = stims[i];
      @(posedge clk_i);
      #1;
      cur_cmd      = '{op: s.op, addr: s.addr, data: s.wdata};
      mem_expect   = (s.kind == 2'd1);
      host_cmd_i   = cur_cmd;
      host_cmd_v_i = 1'b1;
      if (mem_expect)
      begin
        mem_wanted++;
      end
      do @(negedge clk_i); while (!host_cmd_ready_o);
      @(posedge clk_i);
      #1;
      host_cmd_v_i = 1'b0;

      stall = next_rand() % 4;
      repeat (stall)
      begin
        @(posedge clk_i);
        #1;
      end
      host_resp_ready_i = 1'b1;
      do @(negedge clk_i); while (!host_resp_v_o);
      got = host_resp_o;

      exp_resp.op   = s.op;
      exp_resp.addr = s.addr;
      if (s.kind == 2'd1)
      begin
        exp_resp.data = mem_data(cur_cmd);
        check_resp(got, exp_resp, '1);
      end
      else
      begin
        exp_resp.data = s.exp;
        check_resp(got, exp_resp, s.mask);
      end
      if (s.kind == 2'd2)
      begin
        if (have_mtime && got.data <= prev_mtime)
        begin
          $display("[ERROR] mtime got %h, expected above %h", got.data, prev_mtime);
          abort_run();
        end
        prev_mtime = got.data;
        have_mtime = 1'b1;
      end
      check_irq({timer_irq_o, software_irq_o, external_irq_o}, s.irq);
      check_cfg(cfg_bus_o, s.cfg);

      @(posedge clk_i);
      #1;
      host_resp_ready_i = 1'b0;
      @(negedge clk_i);
      if (host_resp_v_o)
      begin
        $display("A second response arrived for one command");
        abort_run();
      end
    end

    if (mem_seen != mem_wanted)
    begin
      $display("Memory port saw %0d commands instead of %0d", mem_seen, mem_wanted);
      abort_run();
    end
    else
    begin
      $display("Result: PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/uc_addr_pkg.sv
hw/uc_msg_pkg.sv
hw/uc_cfg_regs.sv
hw/uc_clint.sv
hw/uc_loopback.sv
hw/uc_cmd_router.sv
hw/uc_lite_top.sv
dv/uc_lite_sva.sv
dv/uc_lite_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the Verilator simulation from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module uc_lite_tb -o uc_lite_sim \
  && ./obj_dir/uc_lite_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: dv/uc_lite_stimulus.txt
# op addr wdata exp_data data_mask irq(timer,sw,ext) cfg_bus kind
# kind 0 local masked check, 1 memory port, 2 mtime read that must grow
0 00200000 0000000000000000 0000000000000001 ffffffffffffffff 0 1000 0
1 00200008 0000000000000005 0000000000000000 ffffffffffffffff 0 1500 0
1 00200010 000000000000000a 0000000000000000 ffffffffffffffff 0 15a0 0
1 00200018 0000000000000003 0000000000000000 ffffffffffffffff 0 15a3 0
1 00200000 0000000000000000 0000000000000000 ffffffffffffffff 0 05a3 0
0 00200008 0000000000000000 0000000000000005 ffffffffffffffff 0 05a3 0
0 00200010 0000000000000000 000000000000000a ffffffffffffffff 0 05a3 0
0 00200018 0000000000000000 0000000000000003 ffffffffffffffff 0 05a3 0
0 00200000 0000000000000000 0000000000000000 ffffffffffffffff 0 05a3 0
0 00200020 0000000000000000 0000000000000000 ffffffffffffffff 0 05a3 0
1 00200028 00000000000000ff 0000000000000000 ffffffffffffffff 0 05a3 0
1 00100000 0000000000000001 0000000000000000 ffffffffffffffff 2 05a3 0
1 0010b000 0000000000000001 0000000000000000 ffffffffffffffff 3 05a3 0
1 00104000 0000000000000010 0000000000000000 ffffffffffffffff 7 05a3 0
0 00104000 0000000000000000 0000000000000010 ffffffffffffffff 7 05a3 0
0 0010bff8 0000000000000000 0000000000000000 0000000000000000 7 05a3 2
0 0010bff8 0000000000000000 0000000000000000 0000000000000000 7 05a3 2
1 00100000 0000000000000000 0000000000000000 ffffffffffffffff 5 05a3 0
1 0010b000 0000000000000000 0000000000000000 ffffffffffffffff 4 05a3 0
1 00104000 ffffffffffffffff 0000000000000000 ffffffffffffffff 0 05a3 0
0 00100000 0000000000000000 0000000000000000 ffffffffffffffff 0 05a3 0
0 0010c000 0000000000000000 0000000000000000 ffffffffffffffff 0 05a3 0
0 00500000 0000000000000000 0000000000000000 ffffffffffffffff 0 05a3 0
1 00f00010 0000000000001234 0000000000000000 ffffffffffffffff 0 05a3 0
0 00700008 0000000000000000 0000000000000000 ffffffffffffffff 0 05a3 0
0 80000000 0000000000000000 0000000000000000 0000000000000000 0 05a3 1
1 80001000 00000000deadbeef 0000000000000000 0000000000000000 0 05a3 1
0 c0001238 0000000000000000 0000000000000000 0000000000000000 0 05a3 1
0 00000100 0000000000000000 0000000000000000 0000000000000000 0 05a3 1
0 00400020 0000000000000000 0000000000000000 0000000000000000 0 05a3 1
1 00300008 0000000000000055 0000000000000000 0000000000000000 0 05a3 1
0 fffffff8 0000000000000000 0000000000000000 0000000000000000 0 05a3 1
0 00200008 0000000000000000 0000000000000005 ffffffffffffffff 0 05a3 0
